//--- common/rvf_settings.svh
// Constants for the RV32 fetch unit
// Include wherever reset values, queue size or fixed encodings are needed
`ifndef RVF_SETTINGS_SVH
`define RVF_SETTINGS_SVH

// Program counter after reset
`define RVF_PC_INIT 32'h0000_0200

// Parcel queue capacity, in 16-bit parcels
`define RVF_QUEUE_DEPTH 8

// addi x0,x0,0
`define RVF_NOP 32'h0000_0013

// Wait for interrupt, issued as a NOP
`define RVF_WFI 32'h1050_0073

`endif

//--- common/rvf_pkg.sv
// Types shared by the fetch unit RTL and its testbench
// Import inside module bodies, use scoped names in port lists
`default_nettype none

`include "rvf_settings.svh"

package rvf_pkg;

  //////////////////////////////
  // Instruction data
  //////////////////////////////

  typedef logic [15:0] parcel_t;  // One RVC sized chunk
  typedef logic [31:0] insn_t;    // Full RV32 instruction

  // Fill level of the parcel queue, 0 up to full
  typedef logic [$clog2(`RVF_QUEUE_DEPTH + 1)-1:0] q_count_t;

  typedef struct packed {
    parcel_t parcel;
    logic    fault;   // Word came back with a bus error
  } queue_entry_t;

  //////////////////////////////
  // Wishbone classic
  //////////////////////////////

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;  // Byte address, word aligned
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  //////////////////////////////
  // Decode side
  //////////////////////////////

  // One instruction handed to decode
  typedef struct packed {
    logic [31:0] pc;
    insn_t       instr;         // Already expanded to 32 bits
    logic        illegal;       // Reserved or unsupported RVC
    logic        access_fault;  // Any consumed parcel faulted
  } fetch_out_t;

endpackage

`default_nettype wire

//--- fetch/fetch_ctrl.sv
// Fetch control: Wishbone master, redirect handling, PC and output register
// Decides when a whole instruction sits at the queue head and consumes it
`timescale 1ns/1ps
`default_nettype none

`include "rvf_settings.svh"

module fetch_ctrl (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire rvf_pkg::wb_rsp_t  wb_rsp_i,
  input  wire                    redirect_i,
  input  wire [31:0]             redirect_pc_i,
  input  wire                    out_ready_i,
  input  wire rvf_pkg::q_count_t q_count_i,
  input  wire                    q_pair_i,
  input  wire rvf_pkg::insn_t    exp_insn_i,
  input  wire                    exp_compressed_i,
  input  wire                    exp_illegal_i,
  input  wire [1:0]              q_head_fault_i,
  output rvf_pkg::wb_req_t       wb_req_o,
  output logic                   q_push_o,
  output logic [31:0]            q_word_o,
  output logic                   q_fault_o,
  output logic                   q_drop_low_o,
  output logic                   q_flush_o,
  output logic [1:0]             q_pop_o,
  output rvf_pkg::fetch_out_t    out_o,
  output logic                   out_valid_o
);
  import rvf_pkg::*;

  // Highest fill level that still leaves room for a whole word
  localparam q_count_t FREE_LIMIT = q_count_t'(`RVF_QUEUE_DEPTH - 2);

  logic        cyc_q;
  logic        discard_q;   // Open transfer belongs to the old stream
  logic        drop_low_q;  // Target was the upper half of a word
  logic [31:0] adr_q;
  logic [31:0] pend_adr_q;  // Redirect target waiting for the bus
  logic [31:0] pc_q;        // PC of the queue head
  logic        out_valid_q;
  fetch_out_t  out_q;
  logic        resp;
  logic        accept;
  logic        present;
  logic        take;
  logic        fault;

  //////////////////////////////
  // Bus side
  //////////////////////////////

  assign resp   = cyc_q & (wb_rsp_i.ack | wb_rsp_i.err);
  assign accept = resp & ~discard_q & ~redirect_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cyc_q     <= 1'b0;
      discard_q <= 1'b0;
    end
    else if (cyc_q)
    begin
      if (resp)
      begin
        cyc_q     <= 1'b0;  // Always idle one cycle between transfers
        discard_q <= 1'b0;
      end
      else if (redirect_i)
        discard_q <= 1'b1;
    end
    else if (!redirect_i && q_count_i <= FREE_LIMIT)
      cyc_q <= 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      adr_q      <= `RVF_PC_INIT & ~32'h3;
      pend_adr_q <= `RVF_PC_INIT & ~32'h3;
      drop_low_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      if (cyc_q && !resp)
        pend_adr_q <= {redirect_pc_i[31:2], 2'b00};  // Bus address held until the end
      else
        adr_q <= {redirect_pc_i[31:2], 2'b00};
      drop_low_q <= redirect_pc_i[1];
    end
    else if (resp && discard_q)
      adr_q <= pend_adr_q;
    else if (accept)
    begin
      adr_q      <= adr_q + 32'd4;
      drop_low_q <= 1'b0;  // Only the first word after a redirect
    end
  end

  assign wb_req_o     = '{cyc: cyc_q, stb: cyc_q, adr: adr_q};
  assign q_push_o     = accept;
  assign q_word_o     = wb_rsp_i.dat;
  assign q_fault_o    = wb_rsp_i.err;
  assign q_drop_low_o = drop_low_q;
  assign q_flush_o    = redirect_i;

  //////////////////////////////
  // Decode side
  //////////////////////////////

  // A 32-bit instruction needs both head parcels
  assign present = exp_compressed_i ? (q_count_i != '0) : q_pair_i;
  assign take    = present & (~out_valid_q | out_ready_i) & ~redirect_i;
  assign q_pop_o = take ? (exp_compressed_i ? 2'd1 : 2'd2) : 2'd0;
  assign fault   = q_head_fault_i[0] | (~exp_compressed_i & q_head_fault_i[1]);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pc_q        <= `RVF_PC_INIT;
      out_valid_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      pc_q        <= redirect_pc_i;
      out_valid_q <= 1'b0;
    end
    else if (take)
    begin
      pc_q        <= pc_q + (exp_compressed_i ? 32'd2 : 32'd4);
      out_valid_q <= 1'b1;
    end
    else if (out_ready_i)
      out_valid_q <= 1'b0;
  end

  // Held steady while decode stalls
  always_ff @(posedge clk_i)
  begin
    if (take)
      out_q <= '{pc: pc_q, instr: exp_insn_i, illegal: exp_illegal_i, access_fault: fault};
  end

  assign out_o       = out_q;
  assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- fetch/parcel_queue.sv
// Parcel queue between the bus and the instruction aligner
// Takes one or two parcels per bus word, releases one or two per instruction
`timescale 1ns/1ps
`default_nettype none

`include "rvf_settings.svh"

module parcel_queue (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire                         push_i,
  input  wire [31:0]                  word_i,
  input  wire                         fault_i,
  input  wire                         drop_low_i,  // Keep only the upper parcel
  input  wire                         flush_i,
  input  wire [1:0]                   pop_i,       // Parcels consumed, 0 to 2
  output rvf_pkg::queue_entry_t [1:0] head_o,
  output rvf_pkg::q_count_t           count_o,
  output logic                        pair_o
);
  import rvf_pkg::*;

  localparam int DEPTH = `RVF_QUEUE_DEPTH;

  queue_entry_t [DEPTH-1:0] q_r;      // Entry 0 is the oldest
  queue_entry_t [DEPTH-1:0] q_nxt;
  queue_entry_t [DEPTH+1:0] q_ext;    // Padded so a pop never reads past the end
  queue_entry_t             lo_entry;
  queue_entry_t             hi_entry;
  q_count_t                 count_r;
  q_count_t                 base;     // Fill level after the pop
  q_count_t                 count_nxt;

  assign lo_entry = '{parcel: word_i[15:0], fault: fault_i};
  assign hi_entry = '{parcel: word_i[31:16], fault: fault_i};
  assign base     = count_r - q_count_t'(pop_i);

  //////////////////////////////
  // Next state
  //////////////////////////////

  // Pop shifts down first, push then appends behind what is left
  always_comb
  begin
    q_ext            = '0;
    q_ext[DEPTH-1:0] = q_r;
    for (int i = 0; i < DEPTH; i++)
    begin
      q_nxt[i] = q_ext[i + int'(pop_i)];
      if (push_i && i == int'(base))
        q_nxt[i] = drop_low_i ? hi_entry : lo_entry;
      if (push_i && !drop_low_i && i == int'(base) + 1)
        q_nxt[i] = hi_entry;   // Upper half right behind the lower
    end
  end

  always_comb
  begin
    count_nxt = base;
    if (push_i)
      count_nxt = base + (drop_low_i ? q_count_t'(1) : q_count_t'(2));
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      count_r <= '0;
    else if (flush_i)
      count_r <= '0;   // Stale parcels become invisible
    else
      count_r <= count_nxt;
  end

  always_ff @(posedge clk_i)
  begin
    q_r <= q_nxt;
  end

  assign head_o  = q_r[1:0];
  assign count_o = count_r;
  assign pair_o  = (count_r >= q_count_t'(2));

endmodule

`default_nettype wire

//--- fetch/rvc_expander.sv
// Instruction length decode and RVC to RV32 expansion
// Purely combinational, looks at the two oldest queue parcels
`timescale 1ns/1ps
`default_nettype none

`include "rvf_settings.svh"

module rvc_expander (
  input  wire rvf_pkg::parcel_t [1:0] head_i,   // Index 0 is the first parcel
  output rvf_pkg::insn_t              insn_o,
  output logic                        compressed_o,
  output logic                        illegal_o
);
  import rvf_pkg::*;

  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_LUI = 7'b0110111;

  parcel_t     p;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rd_p;     // x8..x15 forms
  logic [4:0]  rs2_p;
  logic [11:0] imm6;     // CI immediate, sign extended
  insn_t       word;

  // I-type with funct3 000, covers addi
  function automatic insn_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [4:0] rd_f);
    return {imm, rs1, 3'b000, rd_f, OP_IMM};
  endfunction

  // R-type register ALU ops
  function automatic insn_t enc_r(input logic [6:0] f7, input logic [4:0] rs2_f,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd_f);
    return {f7, rs2_f, rs1, f3, rd_f, OP_REG};
  endfunction

  assign p     = head_i[0];
  assign rd    = p[11:7];
  assign rs2   = p[6:2];
  assign rd_p  = {2'b01, p[9:7]};
  assign rs2_p = {2'b01, p[4:2]};
  assign imm6  = {{6{p[12]}}, p[12], p[6:2]};
  assign word  = {head_i[1], head_i[0]};

  assign compressed_o = (p[1:0] != 2'b11);

  //////////////////////////////
  // Expansion
  //////////////////////////////

  always_comb
  begin
    insn_o    = {16'h0000, p};   // Illegal parcels pass zero extended
    illegal_o = 1'b1;
    if (!compressed_o)
    begin
      illegal_o = 1'b0;
      insn_o    = (word == `RVF_WFI) ? `RVF_NOP : word;   // WFI does nothing here
    end
    else
    begin
      case ({p[15:13], p[1:0]})
        5'b000_01:   // C.NOP and C.ADDI
        begin
          illegal_o = 1'b0;
          insn_o    = (rd == 5'd0) ? `RVF_NOP : enc_i(imm6, rd, rd);
        end
        5'b010_01:   // C.LI
        begin
          illegal_o = 1'b0;
          insn_o    = enc_i(imm6, 5'd0, rd);
        end
        5'b011_01:   // C.LUI, rd 2 would be C.ADDI16SP
        begin
          if (rd != 5'd0 && rd != 5'd2 && {p[12], p[6:2]} != 6'd0)
          begin
            illegal_o = 1'b0;
            insn_o    = {{14{p[12]}}, p[12], p[6:2], rd, OP_LUI};
          end
        end
        5'b100_01:   // Register ALU group, shifts and ANDI not kept
        begin
          if (p[12:10] == 3'b011)
          begin
            illegal_o = 1'b0;
            case (p[6:5])
              2'b00:   insn_o = enc_r(7'b0100000, rs2_p, rd_p, 3'b000, rd_p);  // SUB
              2'b01:   insn_o = enc_r(7'b0000000, rs2_p, rd_p, 3'b100, rd_p);  // XOR
              2'b10:   insn_o = enc_r(7'b0000000, rs2_p, rd_p, 3'b110, rd_p);  // OR
              default: insn_o = enc_r(7'b0000000, rs2_p, rd_p, 3'b111, rd_p);  // AND
            endcase
          end
        end
        5'b100_10:   // C.MV and C.ADD, rs2 zero means a jump or EBREAK
        begin
          if (rs2 != 5'd0)
          begin
            illegal_o = 1'b0;
            insn_o    = enc_r(7'b0000000, rs2, p[12] ? rd : 5'd0, 3'b000, rd);
          end
        end
        default:
        begin
          illegal_o = 1'b1;   // Loads, stores, jumps, branches, reserved
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- fetch/rv_fetch.sv
// RV32 instruction fetch with RVC support
// Reads memory over Wishbone and hands one instruction at a time to decode
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  output rvf_pkg::wb_req_t      wb_req_o,
  input  wire rvf_pkg::wb_rsp_t wb_rsp_i,
  input  wire                   redirect_i,
  input  wire [31:0]            redirect_pc_i,
  output rvf_pkg::fetch_out_t   out_o,
  output logic                  out_valid_o,
  input  wire                   out_ready_i
);
  import rvf_pkg::*;

  // Control to queue
  logic                     q_push;
  logic [31:0]              q_word;
  logic                     q_fault;
  logic                     q_drop_low;
  logic                     q_flush;
  logic [1:0]               q_pop;

  // Queue status and head
  queue_entry_t [1:0]       q_head;
  q_count_t                 q_count;
  logic                     q_pair;

  // Expander results
  insn_t                    exp_insn;
  logic                     exp_compressed;
  logic                     exp_illegal;

  fetch_ctrl i_fetch_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wb_req_o         (wb_req_o),
    .wb_rsp_i         (wb_rsp_i),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .out_ready_i      (out_ready_i),
    .q_count_i        (q_count),
    .q_pair_i         (q_pair),
    .exp_insn_i       (exp_insn),
    .exp_compressed_i (exp_compressed),
    .exp_illegal_i    (exp_illegal),
    .q_head_fault_i   ({q_head[1].fault, q_head[0].fault}),
    .q_push_o         (q_push),
    .q_word_o         (q_word),
    .q_fault_o        (q_fault),
    .q_drop_low_o     (q_drop_low),
    .q_flush_o        (q_flush),
    .q_pop_o          (q_pop),
    .out_o            (out_o),
    .out_valid_o      (out_valid_o)
  );

  parcel_queue i_parcel_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (q_push),
    .word_i     (q_word),
    .fault_i    (q_fault),
    .drop_low_i (q_drop_low),
    .flush_i    (q_flush),
    .pop_i      (q_pop),
    .head_o     (q_head),
    .count_o    (q_count),
    .pair_o     (q_pair)
  );

  // Sees the two oldest parcels, valid or not
  rvc_expander i_rvc_expander (
    .head_i       ({q_head[1].parcel, q_head[0].parcel}),
    .insn_o       (exp_insn),
    .compressed_o (exp_compressed),
    .illegal_o    (exp_illegal)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Clock and reset source for the fetch unit testbench
// Reset is released a short delay after a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 20,  // In ns
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial
  begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/tb_rv_fetch.sv
// Testbench for the RV32 fetch unit
// Wishbone memory with random wait states, a reference decoder and a checker
`timescale 1ns/1ps
`default_nettype none

`include "rvf_settings.svh"

module tb_rv_fetch;
  import rvf_pkg::*;

  localparam int          TIMEOUT = 2000;  // Cycles per wait
  localparam logic [31:0] ERR_LO  = 32'h0000_0500;
  localparam logic [31:0] ERR_HI  = 32'h0000_050f;

  logic        clk_i;
  logic        rst_ni;
  wb_req_t     wb_req_o;
  wb_rsp_t     wb_rsp_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  fetch_out_t  out_o;
  logic        out_valid_o;
  logic        out_ready_i;

  logic [31:0] mem [0:1023];     // 4 KB image, addresses wrap
  integer      seed = 32'h1a7c;
  logic [31:0] rnd;
  int          ready_mode = 0;   // 0 always ready, 1 random
  logic        serving = 1'b0;
  int          wait_left = 0;

  logic        bus_prev_open = 1'b0;  // Request pending without a response
  logic        bus_prev_done = 1'b0;  // Response seen at the last edge
  logic [31:0] bus_prev_adr = '0;

  logic [31:0] exp_pc = `RVF_PC_INIT;
  fetch_out_t  exp_out;
  parcel_t     first;
  int          n_out = 0;
  int          n_comp = 0;
  int          n_illegal = 0;
  int          n_fault = 0;
  int          n_wfi = 0;

  tb_clock_gen #(.HALF_PERIOD(20), .RESET_CYCLES(10)) i_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  rv_fetch i_rv_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_req_o      (wb_req_o),
    .wb_rsp_i      (wb_rsp_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .out_o         (out_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i)
  );

  //////////////////////////////
  // Memory image
  //////////////////////////////

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h0019_660d) + 32'h3c6e_f35f;
  endfunction

  function automatic logic in_err_range(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  function automatic parcel_t parcel_at(input logic [31:0] addr);
    logic [31:0] w;
    w = mem[addr[11:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic load_program();
    for (int i = 0; i < 1024; i++)
      mem[i] = fill_word(32'(i) << 2);
    // 32-bit stream with WFI at the reset PC
    mem[10'h080] = 32'h0010_0093;  // addi x1,x0,1
    mem[10'h081] = 32'h0020_8113;  // addi x2,x1,2
    mem[10'h082] = 32'h0020_81b3;  // add x3,x1,x2
    mem[10'h083] = `RVF_WFI;
    mem[10'h084] = 32'h1234_52b7;  // lui x5,0x12345
    mem[10'h085] = 32'h4011_8333;  // sub x6,x3,x1
    mem[10'h086] = `RVF_WFI;
    mem[10'h087] = 32'hfff0_0393;  // addi x7,x0,-1
    // Mixed code at 0x300, low parcel first
    mem[10'h0c0] = 32'h1575_4515;  // c.li x10,5 / c.addi x10,-3
    mem[10'h0c1] = 32'h0010_0093;
    mem[10'h0c2] = 32'h81b3_0001;  // c.nop, then add straddles
    mem[10'h0c3] = 32'h6585_0020;  // c.lui x11,1
    mem[10'h0c4] = 32'h86aa_767d;  // c.lui x12,-1 / c.mv x13,x10
    mem[10'h0c5] = 32'h8c05_96ae;  // c.add x13,x11 / c.sub x8,x9
    mem[10'h0c6] = 32'h8d4d_8ca9;  // c.xor / c.or
    mem[10'h0c7] = 32'h0073_8df1;  // c.and, then WFI straddles
    mem[10'h0c8] = 32'h0001_1050;
    // Reserved and unsupported parcels at 0x380
    mem[10'h0e0] = 32'ha001_0000;  // All zero / c.j
    mem[10'h0e1] = 32'h6581_4188;  // c.lw / c.lui zero imm
    mem[10'h0e2] = 32'h8082_6141;  // c.addi16sp / c.jr
    mem[10'h0e3] = 32'hc001_9002;  // c.ebreak / c.beqz
    mem[10'h0e4] = 32'hc188_8005;  // c.srli / c.sw
    mem[10'h0e5] = 32'h0010_0093;
    // Into the error range, lui straddles 0x500
    mem[10'h13e] = 32'h0010_0093;
    mem[10'h13f] = 32'h52b7_4515;
    mem[10'h140] = 32'h0001_1234;
  endtask

  //////////////////////////////
  // Reference decoder
  //////////////////////////////

  function automatic fetch_out_t ref_fetch(input logic [31:0] pc);
    fetch_out_t  r;
    parcel_t     p;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    p    = parcel_at(pc);
    w    = {parcel_at(pc + 32'd2), p};
    rd   = p[11:7];
    rs2  = p[6:2];
    rdp  = 5'd8 + {2'b00, p[9:7]};
    rs2p = 5'd8 + {2'b00, p[4:2]};
    imm  = {{6{p[12]}}, p[12], p[6:2]};
    r.pc           = pc;
    r.illegal      = 1'b1;            // Until a kept form matches
    r.instr        = {16'h0000, p};
    r.access_fault = in_err_range(pc);
    if (p[1:0] == 2'b11)
    begin
      r.illegal      = 1'b0;
      r.instr        = (w == `RVF_WFI) ? `RVF_NOP : w;
      r.access_fault = in_err_range(pc) | in_err_range(pc + 32'd2);
    end
    else if (p[1:0] == 2'b01 && p[15:13] == 3'b000)
    begin
      r.illegal = 1'b0;
      r.instr   = (rd == 5'd0) ? `RVF_NOP : {imm, rd, 3'b000, rd, 7'b0010011};
    end
    else if (p[1:0] == 2'b01 && p[15:13] == 3'b010)
    begin
      r.illegal = 1'b0;
      r.instr   = {imm, 5'd0, 3'b000, rd, 7'b0010011};
    end
    else if (p[1:0] == 2'b01 && p[15:13] == 3'b011 && rd != 5'd0 && rd != 5'd2 &&
             imm[5:0] != 6'd0)
    begin
      r.illegal = 1'b0;
      r.instr   = {{14{p[12]}}, imm[5:0], rd, 7'b0110111};
    end
    else if (p[1:0] == 2'b01 && p[15:10] == 6'b100011)
    begin
      f7 = (p[6:5] == 2'b00) ? 7'h20 : 7'h00;   // Only SUB sets funct7
      case (p[6:5])
        2'b00:   f3 = 3'b000;
        2'b01:   f3 = 3'b100;
        2'b10:   f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      r.illegal = 1'b0;
      r.instr   = {f7, rs2p, rdp, f3, rdp, 7'b0110011};
    end
    else if (p[1:0] == 2'b10 && p[15:13] == 3'b100 && rs2 != 5'd0)
    begin
      r.illegal = 1'b0;
      r.instr   = {7'h00, rs2, (p[12] ? rd : 5'd0), 3'b000, rd, 7'b0110011};
    end
    return r;
  endfunction

  task automatic report_value(input string name, input logic [31:0] expv,
                              input logic [31:0] gotv);
    $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expv, gotv);
    $display("RESULT: FAIL");
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("RESULT: FAIL");
  endtask

  //////////////////////////////
  // Bus model and ready source
  //////////////////////////////

  initial
  begin
    wb_rsp_i    = '0;
    out_ready_i = 1'b1;
    forever
    begin
      @(posedge clk_i);
      #2;
      rnd         = $random(seed);
      out_ready_i = (ready_mode == 0) ? 1'b1 : rnd[0];
      wb_rsp_i    = '0;
      if (wb_req_o.cyc && wb_req_o.stb)
      begin
        if (!serving)
        begin
          serving   = 1'b1;
          rnd       = $random(seed);
          wait_left = int'(rnd[1:0]);   // 0 to 3 wait states
        end
        if (wait_left == 0)
        begin
          wb_rsp_i.ack = !in_err_range(wb_req_o.adr);
          wb_rsp_i.err = in_err_range(wb_req_o.adr);
          wb_rsp_i.dat = mem[wb_req_o.adr[11:2]];
          serving      = 1'b0;
        end
        else
          wait_left--;
      end
    end
  end

  // Wishbone classic rules on the master side
  always @(posedge clk_i)
  begin
    if (rst_ni)
    begin
      if (bus_prev_open)
      begin
        assert (wb_req_o.cyc && wb_req_o.stb && wb_req_o.adr == bus_prev_adr)
        else
        begin
          report_failure("bus request changed before its response");
          $fatal(1, "Protocol error");
        end
      end
      if (bus_prev_done)
      begin
        assert (!wb_req_o.cyc && !wb_req_o.stb)
        else
        begin
          report_failure("bus request not dropped after its response");
          $fatal(1, "Protocol error");
        end
      end
      bus_prev_done = wb_req_o.cyc && (wb_rsp_i.ack || wb_rsp_i.err);
      bus_prev_open = wb_req_o.cyc && !bus_prev_done;
      bus_prev_adr  = wb_req_o.adr;
    end
  end

  //////////////////////////////
  // Checker
  //////////////////////////////

  always @(posedge clk_i)
  begin
    if (rst_ni)
    begin
      if (out_valid_o && out_ready_i)
      begin
        exp_out = ref_fetch(exp_pc);
        first   = parcel_at(exp_pc);
        assert (out_o.pc == exp_out.pc)
        else
        begin
          report_value("out_o.pc", exp_out.pc, out_o.pc);
          $fatal(1, "Output mismatch");
        end
        assert (out_o.instr == exp_out.instr)
        else
        begin
          report_value("out_o.instr", exp_out.instr, out_o.instr);
          $fatal(1, "Output mismatch");
        end
        assert (out_o.illegal == exp_out.illegal)
        else
        begin
          report_value("out_o.illegal", 32'(exp_out.illegal), 32'(out_o.illegal));
          $fatal(1, "Output mismatch");
        end
        assert (out_o.access_fault == exp_out.access_fault)
        else
        begin
          report_value("out_o.access_fault", 32'(exp_out.access_fault),
                       32'(out_o.access_fault));
          $fatal(1, "Output mismatch");
        end
        n_out++;
        if (first[1:0] != 2'b11)
          n_comp++;
        else if ({parcel_at(exp_pc + 32'd2), first} == `RVF_WFI)
          n_wfi++;
        if (exp_out.illegal)
          n_illegal++;
        if (exp_out.access_fault)
          n_fault++;
        exp_pc = exp_pc + ((first[1:0] != 2'b11) ? 32'd2 : 32'd4);
      end
      if (redirect_i)
        exp_pc = redirect_pc_i;  // Next instruction taken starts here
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // All tasks below return 2 ns after a rising edge
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_ni && cycles < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!rst_ni)
    begin
      report_failure("reset was never released");
      $fatal(1, "Timeout");
    end
    #1;
  endtask

  task automatic wait_outputs(input int count);
    int target;
    int cycles;
    target = n_out + count;
    cycles = 0;
    while (n_out < target && cycles < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (n_out < target)
    begin
      report_failure("decode outputs stopped arriving");
      $fatal(1, "Timeout");
    end
    #1;
  endtask

  // A transfer that will still be open at the next edge
  task automatic wait_open_cycle();
    int   cycles;
    logic found;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      cycles++;
      found = wb_req_o.cyc && serving && wait_left > 0;
    end
    if (!found)
    begin
      report_failure("no bus transfer with wait states was seen");
      $fatal(1, "Timeout");
    end
    #1;
  endtask

  task automatic drive_redirect(input logic [31:0] target);
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    @(posedge clk_i);
    #2;
    redirect_i = 1'b0;
  endtask

  task automatic set_ready_mode(input int mode);
    @(negedge clk_i);
    ready_mode = mode;
    @(posedge clk_i);
    #2;
  endtask

  initial
  begin
    logic [31:0] targets [0:3];
    targets[0]    = 32'h302;
    targets[1]    = 32'h30a;   // Start of a straddling add
    targets[2]    = 32'h384;
    targets[3]    = 32'h20c;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    load_program();
    wait_reset_release();
    wait_outputs(10);
    drive_redirect(32'h300);   // Mid-stream, to the mixed code
    wait_outputs(16);
    drive_redirect(32'h380);
    wait_outputs(12);
    set_ready_mode(1);         // Decode stalls at random
    drive_redirect(32'h300);
    wait_outputs(40);
    for (int i = 0; i < 4; i++)
    begin
      wait_open_cycle();
      drive_redirect(targets[i]);
      wait_outputs(8);
    end
    set_ready_mode(0);
    drive_redirect(32'h4f8);
    wait_outputs(10);
    if (n_comp > 0 && n_illegal > 0 && n_fault > 0 && n_wfi > 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      report_failure("an expected kind of instruction never came out");
      $fatal(1, "Coverage incomplete");
    end
  end

endmodule

`default_nettype wire

//--- rv_fetch.f
+incdir+common
common/rvf_pkg.sv
fetch/fetch_ctrl.sv
fetch/parcel_queue.sv
fetch/rvc_expander.sv
fetch/rv_fetch.sv
verification/tb_clock_gen.sv
verification/tb_rv_fetch.sv

//--- Makefile
TOP := tb_rv_fetch

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): rv_fetch.f common/rvf_settings.svh common/rvf_pkg.sv fetch/*.sv verification/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f rv_fetch.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
